// ==== common/tcm_enc_pkg.sv ====
// 4D-8PSK TCM encoder definitions

package tcm_enc_pkg;

  // code rate: 0/1/2/3 -> 2/2.25/2.5/2.75 bit per 8PSK symbol
  typedef logic [1:0] code_t;

  // differential coder state width
  localparam int DFC_W = 3;

  // systematic convolutional coder
  localparam int               CONV_M    = 6;         // state width
  localparam logic [CONV_M-1:0] CONV_TAPS = 6'b101101; // parity tap mask

  // mapper
  localparam int IQ_W          = 8;  // signed I/Q sample width
  localparam int SYMS_PER_WORD = 4;  // 8PSK symbols per 4D symbol

  // data word between the dfc and conv stages
  typedef struct packed {
    logic        sop;
    logic        eop;
    logic [11:1] dat;  // up to 11 bits, rate selects how many are used
  } dat_word_t;

  // coded word, written as raw bits and read back as phase fields
  typedef union packed {
    logic [11:0]      raw;    // [11:1] data, [0] parity
    logic [3:0][2:0]  phase;  // field j = raw[3j+2 : 3j]
  } coded_word_u;

  // coded word between conv and the mapper
  typedef struct packed {
    logic        sop;
    logic        eop;
    coded_word_u cw;
  } coded_word_t;

  // one 8PSK output symbol
  typedef struct packed {
    logic [2:0]            phase;
    logic signed [IQ_W-1:0] i;
    logic signed [IQ_W-1:0] q;
    logic                  sop;
    logic                  eop;
  } sym_t;

  // constellation point
  typedef struct packed {
    logic signed [IQ_W-1:0] i;
    logic signed [IQ_W-1:0] q;
  } iq_t;

  // cos/sin of k*45 deg scaled by 100
  localparam iq_t IQ_TABLE [8] = '{
    '{i:  8'sd100, q:  8'sd0  },  // 0 deg
    '{i:  8'sd71,  q:  8'sd71 },  // 45
    '{i:  8'sd0,   q:  8'sd100},  // 90
    '{i: -8'sd71,  q:  8'sd71 },  // 135
    '{i: -8'sd100, q:  8'sd0  },  // 180
    '{i: -8'sd71,  q: -8'sd71 },  // 225
    '{i:  8'sd0,   q: -8'sd100},  // 270
    '{i:  8'sd71,  q: -8'sd71 }   // 315
  };

endpackage

// ==== coder/tcm_enc_dfc.sv ====
// TCM data word differential coder

`timescale 1ns/1ps

module tcm_enc_dfc (
  input  logic                  iclk,
  input  logic                  ireset,
  input  logic                  iclkena,
  input  tcm_enc_pkg::code_t    icode,    // rate select
  input  logic                  i1sps,    // symbol strobe
  input  logic                  ival,     // one 4D symbol = 4 8PSK symbols
  input  tcm_enc_pkg::dat_word_t iword,
  output logic                  o1sps,
  output logic                  oval,
  output tcm_enc_pkg::dat_word_t oword
);

  logic                          accept;
  logic [tcm_enc_pkg::DFC_W-1:0] state;     // running sum mod 8
  logic [tcm_enc_pkg::DFC_W-1:0] base;      // state, cleared at frame start
  logic [tcm_enc_pkg::DFC_W-1:0] x;         // coded bits, next state
  tcm_enc_pkg::dat_word_t        word_nxt;

  assign accept = ival & i1sps;
  assign base   = iword.sop ? '0 : state;   // restart on new frame

  // pick three bits by rate, add state, put the sum back in place
  always_comb begin
    word_nxt = iword;  // unused bits pass through
    x        = '0;
    case (icode)
      2'd0 : begin
        x = {iword.dat[8], iword.dat[5], iword.dat[1]} + base;
        {word_nxt.dat[8], word_nxt.dat[5], word_nxt.dat[1]} = x;
      end
      2'd1 : begin
        x = {iword.dat[9], iword.dat[6], iword.dat[2]} + base;
        {word_nxt.dat[9], word_nxt.dat[6], word_nxt.dat[2]} = x;
      end
      2'd2 : begin
        x = {iword.dat[10], iword.dat[7], iword.dat[3]} + base;
        {word_nxt.dat[10], word_nxt.dat[7], word_nxt.dat[3]} = x;
      end
      default : begin
        x = {iword.dat[11], iword.dat[8], iword.dat[4]} + base;
        {word_nxt.dat[11], word_nxt.dat[8], word_nxt.dat[4]} = x;
      end
    endcase
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval  <= 1'b0;
      o1sps <= 1'b0;
      state <= '0;
    end else if (iclkena) begin
      oval  <= accept;
      o1sps <= i1sps;
      if (accept)
        state <= x;  // carried word to word
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && accept)
      oword <= word_nxt;
  end

endmodule

// ==== coder/tcm_enc_conv.sv ====
// TCM systematic parity coder

`timescale 1ns/1ps

module tcm_enc_conv (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     i1sps,   // strobe, delayed along
  input  logic                     ival,    // already strobe qualified
  input  tcm_enc_pkg::dat_word_t   iword,
  output logic                     o1sps,
  output logic                     oval,
  output tcm_enc_pkg::coded_word_t oword
);

  logic [tcm_enc_pkg::CONV_M-1:0] state;
  logic [tcm_enc_pkg::CONV_M-1:0] base;       // state, zero at frame start
  logic [tcm_enc_pkg::CONV_M-1:0] state_nxt;
  logic                           parity;
  tcm_enc_pkg::coded_word_t       word_nxt;

  assign base = iword.sop ? '0 : state;

  // parity from the tapped state bits
  assign parity = ^(base & tcm_enc_pkg::CONV_TAPS);

  // shift in the three low data bits
  assign state_nxt = {base[tcm_enc_pkg::CONV_M-4:0], iword.dat[3:1]};

  always_comb begin
    word_nxt.sop    = iword.sop;
    word_nxt.eop    = iword.eop;
    word_nxt.cw.raw = {iword.dat, parity};  // systematic part on top
  end

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval  <= 1'b0;
      o1sps <= 1'b0;
      state <= '0;
    end else if (iclkena) begin
      oval  <= ival;
      o1sps <= i1sps;  // keep strobe aligned with oval
      if (ival)
        state <= state_nxt;
    end
  end

  // payload register
  always_ff @(posedge iclk) begin
    if (iclkena && ival)
      oword <= word_nxt;
  end

endmodule

// ==== source/tcm_enc_mapper.sv ====
// TCM 8PSK phase serializer and I/Q mapper

`timescale 1ns/1ps

module tcm_enc_mapper (
  input  logic                     iclk,
  input  logic                     ireset,
  input  logic                     iclkena,
  input  logic                     i1sps,     // symbol strobe
  input  logic                     ival,      // load a coded word
  input  tcm_enc_pkg::coded_word_t iword,
  output tcm_enc_pkg::sym_t        osym,
  output logic                     osym_val
);

  localparam int CNT_W = $clog2(tcm_enc_pkg::SYMS_PER_WORD);

  tcm_enc_pkg::coded_word_t word;   // held word
  logic [CNT_W-1:0]         cnt;    // field index
  logic                     busy;   // fields left to send
  logic                     emit;
  logic                     last;
  logic [2:0]               ph;
  tcm_enc_pkg::iq_t         iq;
  tcm_enc_pkg::sym_t        sym_nxt;

  // one field per strobe while a word is held
  assign emit = busy & i1sps;
  assign last = (cnt == CNT_W'(tcm_enc_pkg::SYMS_PER_WORD - 1));

  // phase field view of the coded word
  assign ph = word.cw.phase[cnt];
  assign iq = tcm_enc_pkg::IQ_TABLE[ph];

  always_comb begin
    sym_nxt.phase = ph;
    sym_nxt.i     = iq.i;
    sym_nxt.q     = iq.q;
    sym_nxt.sop   = word.sop & (cnt == '0);  // frame start on field 0
    sym_nxt.eop   = word.eop & last;         // frame end on field 3
  end

  // field counter and busy flag
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy     <= 1'b0;
      cnt      <= '0;
      osym_val <= 1'b0;
    end else if (iclkena) begin
      osym_val <= emit;
      if (emit)
        cnt <= cnt + 1'b1;  // wraps after last field
      if (ival) begin
        // new word may land together with the last field
        busy <= 1'b1;
        cnt  <= '0;
      end else if (emit && last) begin
        busy <= 1'b0;
      end
    end
  end

  // held word
  always_ff @(posedge iclk) begin
    if (iclkena && ival)
      word <= iword;
  end

  // symbol output, holds between strobes
  always_ff @(posedge iclk) begin
    if (iclkena && emit)
      osym <= sym_nxt;
  end

endmodule

// ==== source/tcm_enc.sv ====
// 4D-8PSK TCM encoder top

`timescale 1ns/1ps

module tcm_enc (
  input  logic                   iclk,
  input  logic                   ireset,
  input  logic                   iclkena,
  input  tcm_enc_pkg::code_t     icode,     // rate select
  input  logic                   i1sps,     // symbol strobe from outside
  input  logic                   ival,      // word valid, strobe qualified
  input  tcm_enc_pkg::dat_word_t iword,
  output tcm_enc_pkg::sym_t      osym,
  output logic                   osym_val,
  output logic                   o1sps      // strobe aligned to coded words
);

  // dfc -> conv
  tcm_enc_pkg::dat_word_t   dfc_word;
  logic                     dfc_val;
  logic                     dfc_1sps;

  // conv -> mapper
  tcm_enc_pkg::coded_word_t conv_word;
  logic                     conv_val;

  // differential coder of the rate selected bits
  tcm_enc_dfc u_dfc (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .icode   (icode),
    .i1sps   (i1sps),
    .ival    (ival),
    .iword   (iword),
    .o1sps   (dfc_1sps),
    .oval    (dfc_val),
    .oword   (dfc_word)
  );

  // parity append
  tcm_enc_conv u_conv (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .i1sps   (dfc_1sps),
    .ival    (dfc_val),
    .iword   (dfc_word),
    .o1sps   (o1sps),     // also drives the mapper strobe
    .oval    (conv_val),
    .oword   (conv_word)
  );

  // four phases out, one per strobe
  tcm_enc_mapper u_mapper (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .i1sps    (o1sps),
    .ival     (conv_val),
    .iword    (conv_word),
    .osym     (osym),
    .osym_val (osym_val)
  );

endmodule

// ==== verification/tb_clk_gen.sv ====
// testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen (
  output logic iclk,
  output logic ireset
);

  localparam realtime HALF_PERIOD  = 20ns;  // 40 ns period
  localparam int      RESET_CYCLES = 16;
  localparam realtime RELEASE_DLY  = 2ns;   // off the rising edge

  initial begin
    iclk = 1'b0;
    forever #(HALF_PERIOD) iclk = ~iclk;
  end

  initial begin
    ireset = 1'b1;
    repeat (RESET_CYCLES) @(posedge iclk);
    #(RELEASE_DLY) ireset = 1'b0;
  end

endmodule

// ==== verification/tcm_enc_checker.sv ====
// TCM encoder reference model and assertions

`timescale 1ns/1ps

module tcm_enc_checker (
  input logic                   iclk,
  input logic                   ireset,
  input logic                   iclkena,
  input tcm_enc_pkg::code_t     icode,
  input logic                   i1sps,
  input logic                   ival,
  input tcm_enc_pkg::dat_word_t iword,
  input tcm_enc_pkg::sym_t      osym,
  input logic                   osym_val,
  input logic                   o1sps
);

  int                err_cnt  = 0;     // failed assertions so far
  logic              fail_val = 1'b0;  // last failure was a value mismatch
  tcm_enc_pkg::sym_t fail_exp;
  tcm_enc_pkg::sym_t fail_act;

  logic [2:0]        dstate;    // model differential state
  logic [5:0]        cstate;    // model parity coder state
  logic [2:0]        dbase;
  logic [2:0]        dsum;
  logic [5:0]        cbase;
  logic [5:0]        cnext;
  logic [11:1]       dcode;     // data after differential coding
  logic              par;
  logic [11:0]       raw;
  int                c;
  tcm_enc_pkg::sym_t exp_word [4];    // symbols of the word being accepted
  tcm_enc_pkg::sym_t exp_mem  [256];  // expected symbol ring
  logic [7:0]        wr_ptr;
  logic [7:0]        rd_ptr;
  logic [7:0]        pending;
  logic [1:0]        gap;       // strobes since last word, saturating
  logic [1:0]        sps_q;     // input strobe through dfc and conv
  logic              ena_q;
  logic              seen;      // at least one symbol out
  logic              accept;
  logic              new_sym;
  tcm_enc_pkg::sym_t exp_sym;

  // cos and sin of k*45 deg, times 100
  function automatic logic [15:0] iq_ref(input logic [2:0] ph);
    case (ph)
      3'd0    : return {8'sd100, 8'sd0};
      3'd1    : return {8'sd71, 8'sd71};
      3'd2    : return {8'sd0, 8'sd100};
      3'd3    : return {-8'sd71, 8'sd71};
      3'd4    : return {-8'sd100, 8'sd0};
      3'd5    : return {-8'sd71, -8'sd71};
      3'd6    : return {8'sd0, -8'sd100};
      default : return {8'sd71, -8'sd71};
    endcase
  endfunction

  // rate c uses bit positions 8+c, 5+c, 1+c
  always_comb begin
    c          = int'(icode);
    dbase      = iword.sop ? 3'd0 : dstate;  // new frame
    dsum       = {iword.dat[8+c], iword.dat[5+c], iword.dat[1+c]} + dbase;
    dcode      = iword.dat;
    dcode[8+c] = dsum[2];
    dcode[5+c] = dsum[1];
    dcode[1+c] = dsum[0];
    cbase      = iword.sop ? 6'd0 : cstate;
    par        = ^(cbase & tcm_enc_pkg::CONV_TAPS);
    cnext      = {cbase[2:0], dcode[3:1]};
    raw        = {dcode, par};
    for (int j = 0; j < 4; j++) begin
      exp_word[j].phase                = raw[3*j +: 3];
      {exp_word[j].i, exp_word[j].q}   = iq_ref(raw[3*j +: 3]);
      exp_word[j].sop                  = iword.sop && (j == 0);
      exp_word[j].eop                  = iword.eop && (j == 3);
    end
  end

  assign accept  = iclkena & i1sps & ival;
  assign new_sym = osym_val & ena_q;     // set on an enabled edge
  assign pending = wr_ptr - rd_ptr;
  assign exp_sym = exp_mem[rd_ptr];

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      dstate <= '0;
      cstate <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      gap    <= 2'd3;
      sps_q  <= '0;
      ena_q  <= 1'b0;
      seen   <= 1'b0;
    end else begin
      ena_q <= iclkena;
      if (iclkena)
        sps_q <= {sps_q[0], i1sps};  // one stage per enabled edge
      if (new_sym) begin
        rd_ptr <= rd_ptr + 8'd1;
        seen   <= 1'b1;
      end
      if (accept) begin
        dstate <= dsum;
        cstate <= cnext;
        wr_ptr <= wr_ptr + 8'd4;  // four fields per word
        gap    <= 2'd0;
      end else if (iclkena && i1sps && gap != 2'd3) begin
        gap <= gap + 2'd1;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (!ireset && accept)
      for (int j = 0; j < 4; j++)
        exp_mem[wr_ptr + 8'(j)] <= exp_word[j];
  end

  a_reset_low : assert property (@(posedge iclk) ireset |-> !osym_val && !o1sps)
    else begin
      fail_val = 1'b0;
      err_cnt++;
      $error("osym_val or o1sps high during reset");
    end

  // strobe out of the conv register
  a_strobe : assert property (@(posedge iclk) disable iff (ireset) o1sps == sps_q[1])
    else begin
      fail_val = 1'b0;
      err_cnt++;
      $error("o1sps does not follow i1sps by two enabled cycles");
    end

  a_no_extra : assert property (@(posedge iclk) disable iff (ireset) new_sym |-> pending != 0)
    else begin
      fail_val = 1'b0;
      err_cnt++;
      $error("symbol out with no word pending");
    end

  a_phase : assert property (@(posedge iclk) disable iff (ireset)
    new_sym |-> osym.phase == exp_sym.phase)
    else begin
      fail_val = 1'b1;
      fail_exp = $sampled(exp_sym);
      fail_act = $sampled(osym);
      err_cnt++;
      $error("phase differs from model");
    end

  a_iq : assert property (@(posedge iclk) disable iff (ireset)
    new_sym |-> {osym.i, osym.q} == iq_ref(osym.phase))
    else begin
      fail_val = 1'b1;
      fail_exp = $sampled(exp_sym);
      fail_act = $sampled(osym);
      err_cnt++;
      $error("I/Q not the table entry of the phase");
    end

  a_frame : assert property (@(posedge iclk) disable iff (ireset)
    new_sym |-> osym.sop == exp_sym.sop && osym.eop == exp_sym.eop)
    else begin
      fail_val = 1'b1;
      fail_exp = $sampled(exp_sym);
      fail_act = $sampled(osym);
      err_cnt++;
      $error("sop or eop on the wrong symbol");
    end

  a_hold_val : assert property (@(posedge iclk) disable iff (ireset)
    !iclkena |=> $stable(osym_val))
    else begin
      fail_val = 1'b0;
      err_cnt++;
      $error("osym_val moved with clock enable low");
    end

  a_hold_sym : assert property (@(posedge iclk) disable iff (ireset)
    !iclkena && seen |=> $stable(osym))
    else begin
      fail_val = 1'b0;
      err_cnt++;
      $error("osym moved with clock enable low");
    end

  // a word only on every fourth strobe
  a_spacing : assert property (@(posedge iclk) disable iff (ireset) accept |-> gap == 2'd3)
    else begin
      fail_val = 1'b0;
      err_cnt++;
      $error("new word while the mapper is still busy");
    end

endmodule

// ==== verification/tb_tcm_enc.sv ====
// TCM encoder testbench

`timescale 1ns/1ps

module tb_tcm_enc;

  localparam int      N_CODES   = 4;
  localparam int      FRAME_LEN = 6;    // words per frame
  localparam int      WORD_CYC  = 12;   // enabled cycles per word
  localparam int      RESET_CYC = 16;
  localparam int      MARGIN    = 100;
  localparam int      MAX_CYC   = RESET_CYC + (N_CODES + 1) * FRAME_LEN * WORD_CYC * 2 + MARGIN;
  localparam realtime DRIVE_DLY = 2ns;

  logic                   iclk;
  logic                   ireset;
  logic                   iclkena;
  tcm_enc_pkg::code_t     icode;
  logic                   i1sps;
  logic                   ival;
  tcm_enc_pkg::dat_word_t iword;
  tcm_enc_pkg::sym_t      osym;
  logic                   osym_val;
  logic                   o1sps;

  int    seed    = 88;
  int    cyc_cnt = 0;
  string test_name;

  tb_clk_gen u_clk_gen (
    .iclk   (iclk),
    .ireset (ireset)
  );

  tcm_enc i_dut (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .icode    (icode),
    .i1sps    (i1sps),
    .ival     (ival),
    .iword    (iword),
    .osym     (osym),
    .osym_val (osym_val),
    .o1sps    (o1sps)
  );

  bind tcm_enc tcm_enc_checker u_chk (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .icode    (icode),
    .i1sps    (i1sps),
    .ival     (ival),
    .iword    (iword),
    .osym     (osym),
    .osym_val (osym_val),
    .o1sps    (o1sps)
  );

  function automatic string fmt_sym(input tcm_enc_pkg::sym_t s);
    return $sformatf("phase %0d i %0d q %0d sop %b eop %b", s.phase, s.i, s.q, s.sop, s.eop);
  endfunction

  // one word over 12 enabled cycles, strobe every third, word on the first
  task automatic send_word(input logic sop, input logic eop, input logic toggle);
    logic [31:0] r;
    int          k;
    k = 0;
    while (k < WORD_CYC) begin
      @(posedge iclk);
      #(DRIVE_DLY);
      r       = $random(seed);
      iclkena = toggle ? (r[1:0] != 2'b00) : 1'b1;  // about 3 of 4 enabled
      r       = $random(seed);
      if (iclkena) begin
        i1sps     = (k % 3 == 0);
        ival      = (k == 0);
        iword.sop = (k == 0) && sop;
        iword.eop = (k == 0) && eop;
        iword.dat = r[10:0];  // junk while not valid
        k++;
      end else begin
        i1sps = 1'b0;
        ival  = 1'b0;
      end
    end
  endtask

  task automatic run_frame(input tcm_enc_pkg::code_t code, input logic toggle);
    icode = code;
    for (int w = 0; w < FRAME_LEN; w++)
      send_word(w == 0, w == FRAME_LEN - 1, toggle);
  endtask

  // keep strobing until the checker has seen every expected symbol
  task automatic drain();
    int k;
    k = 0;
    while (i_dut.u_chk.pending != 0) begin
      @(posedge iclk);
      #(DRIVE_DLY);
      iclkena = 1'b1;
      i1sps   = (k % 3 == 0);
      ival    = 1'b0;
      k++;
    end
    i1sps = 1'b0;
    repeat (4) @(posedge iclk);
  endtask

  initial begin
    iclkena   = 1'b1;
    icode     = '0;
    i1sps     = 1'b0;
    ival      = 1'b0;
    iword     = '0;
    test_name = "reset";
    @(negedge ireset);
    for (int c = 0; c < N_CODES; c++) begin
      test_name = $sformatf("code_rate_%0d", c);
      run_frame(tcm_enc_pkg::code_t'(c), 1'b0);
    end
    test_name = "clock_enable_toggle";
    run_frame(2'd3, 1'b1);
    test_name = "drain";
    drain();
    if (i_dut.u_chk.err_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "checker reported errors");
    end
  end

  // first checker failure ends the run
  initial begin
    wait (i_dut.u_chk.err_cnt != 0);
    if (i_dut.u_chk.fail_val)
      $display("[FAIL] %s: expected %s, actual %s", test_name,
               fmt_sym(i_dut.u_chk.fail_exp), fmt_sym(i_dut.u_chk.fail_act));
    else
      $display("checker flagged a reset, hold, strobe or word spacing error during %s",
               test_name);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  end

  always @(posedge iclk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC) begin
      $display("timeout: run did not finish within %0d cycles during %s", MAX_CYC, test_name);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

// ==== tcm_enc.f ====
common/tcm_enc_pkg.sv
coder/tcm_enc_dfc.sv
coder/tcm_enc_conv.sv
source/tcm_enc_mapper.sv
source/tcm_enc.sv
verification/tb_clk_gen.sv
verification/tcm_enc_checker.sv
verification/tb_tcm_enc.sv
